// File: source/msx_pkg.sv
`default_nettype none

package msx_pkg;

    // Widths of the CPU side of the bus
    localparam int ADDR_BITS = 16;
    localparam int DATA_BITS = 8;

    // A 16 KB page is addressed by the low 14 bits of the CPU address
    localparam int PAGE_BITS = 14;

    // 16 installed segments of 16 KB make up the 256 KB mapped RAM
    localparam int SEGMENT_BITS   = 4;
    localparam int PHYS_ADDR_BITS = SEGMENT_BITS + PAGE_BITS;
    localparam int RAM_BYTES      = 1 << PHYS_ADDR_BITS;

    localparam int NUM_LATCH_DEVICES = 3;

    typedef logic [ADDR_BITS-1:0]      addr_t;
    typedef logic [DATA_BITS-1:0]      data_t;
    typedef logic [DATA_BITS-1:0]      seg_t;
    typedef logic [PHYS_ADDR_BITS-1:0] phys_addr_t;

    // Page number of the CPU address, which is also the device reference
    typedef logic [ADDR_BITS-PAGE_BITS-1:0] dev_ref_t;

    // Segment seen by a page that no device serves
    localparam seg_t UNMAPPED_SEGMENT = 8'hFF;

    // The latches are write-only, so any I/O read floats high
    localparam data_t IO_READ_DATA = 8'hFF;

    // One entry of the I/O port decode table
    typedef struct packed {
        logic [7:0] port;
        logic [7:0] mask;
        logic       enable;
        dev_ref_t   device_ref;
    } io_device_t;

    // Ports FD, FE and FF serve pages 1, 2 and 3
    localparam io_device_t IO_DEVICES [0:NUM_LATCH_DEVICES-1] = '{
        '{port: 8'hFD, mask: 8'hFF, enable: 1'b1, device_ref: 2'd1},
        '{port: 8'hFE, mask: 8'hFF, enable: 1'b1, device_ref: 2'd2},
        '{port: 8'hFF, mask: 8'hFF, enable: 1'b1, device_ref: 2'd3}
    };

endpackage

`default_nettype wire

// File: source/cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if
    import msx_pkg::*;
(
    input logic clk,
    input logic reset
);

    // Transfer strobe, high for exactly one cycle per transaction
    logic     req;
    addr_t    addr;
    data_t    data_w;
    data_t    data_r;
    logic     wr;
    logic     iorq;
    // Marks an interrupt acknowledge when it comes with iorq
    logic     m1;

    // Page select from the mapper and the segment the latch device returns for it
    dev_ref_t device_ref;
    seg_t     segment;

    // The arbiter owns the cycle and reads the registered data back
    modport master_mp (
        input  clk, reset, data_r,
        output req, addr, data_w, wr, iorq, m1
    );

    // The latch device decodes I/O writes and answers the page lookup
    modport device_mp (
        input  clk, reset, req, addr, data_w, wr, iorq, m1, device_ref,
        output segment
    );

    // The mapper asks for the segment of the current page and drives read data
    modport mapper_mp (
        input  clk, reset, req, addr, data_w, wr, iorq, segment,
        output device_ref, data_r
    );

endinterface

`default_nettype wire

// File: source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import msx_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    input  logic  cpu_req,
    output logic  cpu_ack,
    input  addr_t cpu_addr,
    input  data_t cpu_wdata,
    output data_t cpu_rdata,
    input  logic  cpu_wr,
    input  logic  cpu_iorq,
    input  logic  cpu_m1,

    input  logic  dma_req,
    output logic  dma_ack,
    input  addr_t dma_addr,
    input  data_t dma_wdata,
    output data_t dma_rdata,
    input  logic  dma_wr,
    input  logic  dma_iorq,
    input  logic  dma_m1,

    cpu_bus_if.master_mp bus
);

    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        CAPTURE,
        ACK
    } arb_state_t;

    arb_state_t state;

    // Set when the DMA port was granted most recently, and holds the grant
    // for the whole transaction
    logic last_served;

    // Grant decision taken while idle
    logic pick_dma;
    logic any_req;
    logic granted_req;

    // On contention the master that was not served last wins
    assign any_req  = cpu_req || dma_req;
    assign pick_dma = dma_req && (!cpu_req || !last_served);

    // Request line of the master that owns the current transaction
    assign granted_req = last_served ? dma_req : cpu_req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            last_served <= 1'b1;
            bus.req     <= 1'b0;
            bus.wr      <= 1'b0;
            bus.iorq    <= 1'b0;
            bus.m1      <= 1'b0;
            cpu_ack     <= 1'b0;
            dma_ack     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (any_req) begin
                        // Put the winner's cycle on the bus for one cycle
                        last_served <= pick_dma;
                        bus.req     <= 1'b1;
                        bus.wr      <= pick_dma ? dma_wr   : cpu_wr;
                        bus.iorq    <= pick_dma ? dma_iorq : cpu_iorq;
                        bus.m1      <= pick_dma ? dma_m1   : cpu_m1;
                        state       <= STROBE;
                    end
                end
                STROBE: begin
                    // Mapper and latches act on this edge
                    bus.req <= 1'b0;
                    state   <= CAPTURE;
                end
                CAPTURE: begin
                    if (last_served) begin
                        dma_ack <= 1'b1;
                    end else begin
                        cpu_ack <= 1'b1;
                    end
                    state <= ACK;
                end
                ACK: begin
                    // Hold ack until the master lets go of its request
                    if (!granted_req) begin
                        cpu_ack <= 1'b0;
                        dma_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // The winner's address and write data go onto the bus together with the strobe
    always_ff @(posedge clk) begin
        if (state == IDLE && any_req) begin
            bus.addr   <= pick_dma ? dma_addr  : cpu_addr;
            bus.data_w <= pick_dma ? dma_wdata : cpu_wdata;
        end
    end

    // Read data is handed to the granted master together with its ack
    always_ff @(posedge clk) begin
        if (state == CAPTURE) begin
            if (last_served) begin
                dma_rdata <= bus.data_r;
            end else begin
                cpu_rdata <= bus.data_r;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dev_latch_port.sv
`timescale 1ns/1ps
`default_nettype none

module dev_latch_port
    import msx_pkg::*;
(
    cpu_bus_if.device_mp bus
);

    seg_t latch_value [0:NUM_LATCH_DEVICES-1];

    // Only a plain I/O cycle can reach a latch, never an interrupt acknowledge
    logic io_write;

    assign io_write = bus.req && bus.iorq && !bus.m1 && bus.wr;

    // Segment for the page the mapper is looking at
    always_comb begin
        bus.segment = UNMAPPED_SEGMENT;
        for (int i = 0; i < NUM_LATCH_DEVICES; i++) begin
            if (IO_DEVICES[i].enable && IO_DEVICES[i].device_ref == bus.device_ref) begin
                bus.segment = latch_value[i];
            end
        end
    end

    for (genvar i = 0; i < NUM_LATCH_DEVICES; i++) begin : gen_latch
        logic hit;

        // Masked low address byte against the table entry
        assign hit = IO_DEVICES[i].enable &&
                     ((bus.addr[7:0] & IO_DEVICES[i].mask) == IO_DEVICES[i].port);

        latch_port u_latch (
            .clk     (bus.clk),
            .reset   (bus.reset),
            .data    (bus.data_w),
            .wr      (io_write && hit),
            .segment (latch_value[i])
        );
    end

endmodule

module latch_port
    import msx_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  data_t data,
    input  logic  wr,
    output seg_t  segment
);

    // Every latch selects segment 0 out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            segment <= '0;
        end else if (wr) begin
            segment <= data;
        end
    end

endmodule

`default_nettype wire

// File: source/memory_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module memory_mapper
    import msx_pkg::*;
(
    cpu_bus_if.mapper_mp bus
);

    // 16 segments of 16 KB
    data_t ram [0:RAM_BYTES-1];

    phys_addr_t phys_addr;
    logic       mem_write;
    logic       mem_read;

    // The top two address bits pick the page, and the page is the device reference
    assign bus.device_ref = bus.addr[ADDR_BITS-1:PAGE_BITS];

    // Segment values beyond the installed RAM wrap around, so 8'hFF lands on segment 15
    assign phys_addr = {bus.segment[SEGMENT_BITS-1:0], bus.addr[PAGE_BITS-1:0]};

    assign mem_write = bus.req && !bus.iorq && bus.wr;
    assign mem_read  = bus.req && !bus.iorq && !bus.wr;

    always_ff @(posedge bus.clk) begin
        if (mem_write) begin
            ram[phys_addr] <= bus.data_w;
        end
    end

    // Read data is registered on the edge that ends the strobe
    // and a memory write leaves the last value in place
    always_ff @(posedge bus.clk or posedge bus.reset) begin
        if (bus.reset) begin
            bus.data_r <= IO_READ_DATA;
        end else if (bus.req && bus.iorq) begin
            bus.data_r <= IO_READ_DATA;
        end else if (mem_read) begin
            bus.data_r <= ram[phys_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/mapper_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mapper_subsystem
    import msx_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    input  logic  cpu_req,
    output logic  cpu_ack,
    input  addr_t cpu_addr,
    input  data_t cpu_wdata,
    output data_t cpu_rdata,
    input  logic  cpu_wr,
    input  logic  cpu_iorq,
    input  logic  cpu_m1,

    input  logic  dma_req,
    output logic  dma_ack,
    input  addr_t dma_addr,
    input  data_t dma_wdata,
    output data_t dma_rdata,
    input  logic  dma_wr,
    input  logic  dma_iorq,
    input  logic  dma_m1
);

    // Shared internal CPU bus
    cpu_bus_if bus (
        .clk   (clk),
        .reset (reset)
    );

    // Two masters are folded into single strobed cycles
    bus_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_ack   (cpu_ack),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_wr    (cpu_wr),
        .cpu_iorq  (cpu_iorq),
        .cpu_m1    (cpu_m1),
        .dma_req   (dma_req),
        .dma_ack   (dma_ack),
        .dma_addr  (dma_addr),
        .dma_wdata (dma_wdata),
        .dma_rdata (dma_rdata),
        .dma_wr    (dma_wr),
        .dma_iorq  (dma_iorq),
        .dma_m1    (dma_m1),
        .bus       (bus.master_mp)
    );

    // Segment latches on ports FD to FF
    dev_latch_port u_latches (
        .bus (bus.device_mp)
    );

    // Page translation and the mapped RAM
    memory_mapper u_mapper (
        .bus (bus.mapper_mp)
    );

endmodule

`default_nettype wire

// File: dv/mapper_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mapper_subsystem_properties (
    input logic clk,
    input logic reset,
    input logic cpu_req,
    input logic cpu_ack,
    input logic dma_req,
    input logic dma_ack,
    input logic bus_req
);

    // An ack may only drop once the master has released its request
    cpu_ack_release: assert property (@(posedge clk) disable iff (reset)
        $fell(cpu_ack) |-> !$past(cpu_req))
        else $error("cpu_ack fell while cpu_req was still high");

    dma_ack_release: assert property (@(posedge clk) disable iff (reset)
        $fell(dma_ack) |-> !$past(dma_req))
        else $error("dma_ack fell while dma_req was still high");

    // The bus strobe marks exactly one cycle per transaction
    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        bus_req |=> !bus_req)
        else $error("Bus strobe stayed high for more than one cycle");

    // Only one master owns the bus at a time
    acks_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(cpu_ack && dma_ack))
        else $error("cpu_ack and dma_ack were high together");

endmodule

bind bus_arbiter mapper_subsystem_properties u_props (
    .clk     (clk),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_ack (cpu_ack),
    .dma_req (dma_req),
    .dma_ack (dma_ack),
    .bus_req (bus.req)
);

`default_nettype wire

// File: dv/mapper_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mapper_subsystem_tb
    import msx_pkg::*;
;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int N_DIRECTED = 16;
    // Random transactions per master
    localparam int N_RANDOM = 60;
    localparam int N_TOTAL = N_DIRECTED + 2 * N_RANDOM;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * N_TOTAL;
    localparam int MEM_BYTES = 1 << 18;

    logic  clk;
    logic  reset;
    logic  cpu_req, cpu_ack, cpu_wr, cpu_iorq, cpu_m1;
    addr_t cpu_addr;
    data_t cpu_wdata, cpu_rdata;
    logic  dma_req, dma_ack, dma_wr, dma_iorq, dma_m1;
    addr_t dma_addr;
    data_t dma_wdata, dma_rdata;

    // Reference model of the three segment latches and the mapped RAM
    seg_t  ref_latch [0:2];
    data_t ref_mem [0:MEM_BYTES-1];
    // Locations never written hold unknown data in the DUT and are not compared
    bit    written [0:MEM_BYTES-1];

    logic [31:0] rng_state;
    int          issued;
    int          acks_seen;
    logic        cpu_ack_d;
    logic        dma_ack_d;

    mapper_subsystem uut (
        .clk (clk), .reset (reset),
        .cpu_req (cpu_req), .cpu_ack (cpu_ack), .cpu_addr (cpu_addr),
        .cpu_wdata (cpu_wdata), .cpu_rdata (cpu_rdata), .cpu_wr (cpu_wr),
        .cpu_iorq (cpu_iorq), .cpu_m1 (cpu_m1),
        .dma_req (dma_req), .dma_ack (dma_ack), .dma_addr (dma_addr),
        .dma_wdata (dma_wdata), .dma_rdata (dma_rdata), .dma_wr (dma_wr),
        .dma_iorq (dma_iorq), .dma_m1 (dma_m1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        lcg_step = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Page 0 has no latch and pages 1 to 3 follow ports FD to FF
    function automatic seg_t page_segment(input addr_t addr);
        case (addr[15:14])
            2'd1: page_segment = ref_latch[0];
            2'd2: page_segment = ref_latch[1];
            2'd3: page_segment = ref_latch[2];
            default: page_segment = 8'hFF;
        endcase
    endfunction

    // Only 16 segments are installed, so the upper segment bits are dropped
    function automatic logic [17:0] phys_of(input addr_t addr);
        seg_t seg;
        seg = page_segment(addr);
        phys_of = {seg[3:0], addr[13:0]};
    endfunction

    function automatic data_t expected_read(input addr_t addr, input logic iorq);
        expected_read = iorq ? 8'hFF : ref_mem[phys_of(addr)];
    endfunction

    task automatic report_mismatch(input string who, input addr_t addr,
                                   input data_t exp, input data_t got);
        $display("FAILED at %0t: %s read of %h returned %h, expected %h",
                 $time, who, addr, got, exp);
        $display("RESULT: FAIL");
        $fatal(1, "Read data mismatch");
    endtask

    // Transactions reach the model in the order the arbiter acknowledges them
    task automatic apply_to_model(input string who, input addr_t addr, input data_t wdata,
                                  input logic wr, input logic iorq, input logic m1,
                                  input data_t rdata);
        logic [17:0] pa;
        data_t       exp;
        pa = phys_of(addr);
        acks_seen++;
        if (!wr && (iorq || written[pa])) begin
            exp = expected_read(addr, iorq);
            assert (rdata === exp) else report_mismatch(who, addr, exp, rdata);
        end
        if (iorq && wr && !m1) begin
            case (addr[7:0])
                8'hFD: ref_latch[0] = wdata;
                8'hFE: ref_latch[1] = wdata;
                8'hFF: ref_latch[2] = wdata;
                default: ;
            endcase
        end else if (!iorq && wr) begin
            ref_mem[pa] = wdata;
            written[pa] = 1'b1;
        end
    endtask

    // The compare process samples on the falling edge where ack is stable
    always @(negedge clk) begin
        if (cpu_ack && !cpu_ack_d)
            apply_to_model("cpu", cpu_addr, cpu_wdata, cpu_wr, cpu_iorq, cpu_m1, cpu_rdata);
        if (dma_ack && !dma_ack_d)
            apply_to_model("dma", dma_addr, dma_wdata, dma_wr, dma_iorq, dma_m1, dma_rdata);
        cpu_ack_d = cpu_ack;
        dma_ack_d = dma_ack;
    end

    task automatic cpu_access(input addr_t addr, input data_t wdata,
                              input logic wr, input logic iorq, input logic m1);
        @(posedge clk);
        #1;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_wr    = wr;
        cpu_iorq  = iorq;
        cpu_m1    = m1;
        cpu_req   = 1'b1;
        issued++;
        do begin
            @(posedge clk);
            #1;
        end while (!cpu_ack);
        cpu_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (cpu_ack);
    endtask

    task automatic dma_access(input addr_t addr, input data_t wdata,
                              input logic wr, input logic iorq, input logic m1);
        @(posedge clk);
        #1;
        dma_addr  = addr;
        dma_wdata = wdata;
        dma_wr    = wr;
        dma_iorq  = iorq;
        dma_m1    = m1;
        dma_req   = 1'b1;
        issued++;
        do begin
            @(posedge clk);
            #1;
        end while (!dma_ack);
        dma_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (dma_ack);
    endtask

    // Memory offsets are kept small so that reads often hit written bytes
    task automatic random_txn(input logic use_dma);
        logic [31:0] r;
        addr_t       a;
        logic        wr;
        logic        iorq;
        logic        m1;
        rng_state = lcg_step(rng_state);
        r = rng_state;
        iorq = r[10:8] >= 3'd6;
        wr = (r[10:8] <= 3'd2) || (r[10:8] == 3'd6);
        // A rare interrupt acknowledge among the I/O writes
        m1 = iorq && wr && (r[13:12] == 2'b11);
        a = iorq ? {8'h00, 6'b111111, r[26:25]} : {r[31:30], 11'b0, r[29:27]};
        repeat (r[15:14]) @(posedge clk);
        if (use_dma)
            dma_access(a, r[23:16], wr, iorq, m1);
        else
            cpu_access(a, r[23:16], wr, iorq, m1);
    endtask

    initial begin
        reset = 1'b1;
        {cpu_req, cpu_wr, cpu_iorq, cpu_m1} = '0;
        {dma_req, dma_wr, dma_iorq, dma_m1} = '0;
        cpu_addr = '0;
        cpu_wdata = '0;
        dma_addr = '0;
        dma_wdata = '0;
        cpu_ack_d = 1'b0;
        dma_ack_d = 1'b0;
        ref_latch = '{8'h00, 8'h00, 8'h00};
        rng_state = 32'hbdcc077c;
        issued = 0;
        acks_seen = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // After reset pages 1 to 3 sit on segment 0 and page 0 on segment 15
        cpu_access(16'h4010, 8'hA5, 1'b1, 1'b0, 1'b0);
        cpu_access(16'h0010, 8'h5A, 1'b1, 1'b0, 1'b0);
        cpu_access(16'h4010, 8'h00, 1'b0, 1'b0, 1'b0);
        cpu_access(16'h8010, 8'h00, 1'b0, 1'b0, 1'b0);
        cpu_access(16'hC010, 8'h00, 1'b0, 1'b0, 1'b0);
        cpu_access(16'h0010, 8'h00, 1'b0, 1'b0, 1'b0);

        // Move pages 1 to 3 onto segment 3 and reach the last one through 8'h13
        cpu_access(16'h00FD, 8'h03, 1'b1, 1'b1, 1'b0);
        cpu_access(16'h4020, 8'h33, 1'b1, 1'b0, 1'b0);
        cpu_access(16'h00FE, 8'h03, 1'b1, 1'b1, 1'b0);
        cpu_access(16'h8020, 8'h00, 1'b0, 1'b0, 1'b0);
        cpu_access(16'h00FF, 8'h13, 1'b1, 1'b1, 1'b0);
        cpu_access(16'hC020, 8'h00, 1'b0, 1'b0, 1'b0);

        // Interrupt acknowledge and an unlisted port leave page 1 alone
        cpu_access(16'h00FD, 8'h07, 1'b1, 1'b1, 1'b1);
        cpu_access(16'h00FC, 8'h09, 1'b1, 1'b1, 1'b0);
        cpu_access(16'h4020, 8'h00, 1'b0, 1'b0, 1'b0);
        cpu_access(16'h00FD, 8'h00, 1'b0, 1'b1, 1'b0);

        // Both masters compete for the bus
        fork
            repeat (N_RANDOM) random_txn(1'b0);
            repeat (N_RANDOM) random_txn(1'b1);
        join

        @(posedge clk);
        assert (acks_seen == issued) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("FAILED at %0t: %0d transactions issued but %0d acknowledged",
                     $time, issued, acks_seen);
            $display("RESULT: FAIL");
            $fatal(1, "Transaction count mismatch");
        end
    end

    // Watchdog sized from the number of transactions
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Simulation timed out before all transactions completed");
        $display("RESULT: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// File: filelist.f
source/msx_pkg.sv
source/cpu_bus_if.sv
source/bus_arbiter.sv
source/dev_latch_port.sv
source/memory_mapper.sv
source/mapper_subsystem.sv
dv/mapper_subsystem_properties.sv
dv/mapper_subsystem_tb.sv

// File: Makefile
TOP = mapper_subsystem_tb

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
